/* remove_v_pkg.sv */
// top border removal definitions
package remove_v_pkg;

    // number of pixel streams sharing the engine
    localparam int FLUX_COUNT = 2;

    // flux number carried in the output word
    localparam int TAG_W = $clog2(FLUX_COUNT);

    // pixel and size widths
    localparam int PEL_W = 8;
    localparam int SIZE_W = 7;

    // output word is {tag, pixel}
    localparam int OUT_W = TAG_W + PEL_W;

    // rows removed at the top of every frame
    localparam int DROP_ROWS = 7;

    // per-flux phase codes
    localparam int PHASE_W = 2;
    localparam int PH_IDLE = 0;
    localparam int PH_DROP = 1;
    localparam int PH_WORK = 2;

endpackage

/* ctx_if.sv */
// per-flux context bus
`timescale 1ns/1ps

interface ctx_if import remove_v_pkg::*; ();

    // flux being operated on this cycle
    logic [TAG_W-1:0]  sel_tag;
    logic              op_valid;

    // stored context of the selected flux
    logic [SIZE_W-1:0] cnt_h;
    logic [SIZE_W-1:0] cnt_v;
    logic [SIZE_W-1:0] max_h;
    logic [SIZE_W-1:0] max_v;

    // update values, written at the next edge
    logic [SIZE_W-1:0] cnt_h_next;
    logic [SIZE_W-1:0] cnt_v_next;
    logic [SIZE_W-1:0] max_h_next;
    logic [SIZE_W-1:0] max_v_next;
    logic              cnt_we;
    logic              max_we;

    modport store
    (
        input  sel_tag, op_valid,
        input  cnt_h_next, cnt_v_next, max_h_next, max_v_next, cnt_we, max_we,
        output cnt_h, cnt_v, max_h, max_v
    );

    modport ctrl
    (
        output sel_tag, op_valid,
        output cnt_h_next, cnt_v_next, max_h_next, max_v_next, cnt_we, max_we,
        input  cnt_h, cnt_v, max_h, max_v
    );

endinterface

/* flux_arbiter.sv */
// fixed priority flux arbiter
`timescale 1ns/1ps

module flux_arbiter import remove_v_pkg::*;
(
    input  logic [FLUX_COUNT-1:0][PHASE_W-1:0] phase,
    input  logic [FLUX_COUNT-1:0]              pel_empty,
    input  logic [FLUX_COUNT-1:0]              ext_size_empty,
    input  logic [FLUX_COUNT-1:0]              real_size_empty,
    input  logic [FLUX_COUNT-1:0]              out_full,
    output logic                               grant_valid,
    output logic [TAG_W-1:0]                   grant_tag
);

    logic [FLUX_COUNT-1:0] eligible;

    always_comb
    begin
        for (int i = 0; i < FLUX_COUNT; i++)
        begin
            // idle flux needs both sizes of its next frame
            // dropping flux only needs a pixel
            // working flux also needs room at the output
            eligible[i] =
                (phase[i] == PHASE_W'(PH_IDLE) && !ext_size_empty[i] && !real_size_empty[i])
                || (phase[i] == PHASE_W'(PH_DROP) && !pel_empty[i])
                || (phase[i] == PHASE_W'(PH_WORK) && !pel_empty[i] && !out_full[i]);
        end

        // walk down so the lowest index is kept
        grant_valid = 1'b0;
        grant_tag = '0;
        for (int i = FLUX_COUNT - 1; i >= 0; i--)
        begin
            if (eligible[i])
            begin
                grant_valid = 1'b1;
                grant_tag = TAG_W'(i);
            end
        end
    end

endmodule

/* context_store.sv */
// per-flux frame context registers
`timescale 1ns/1ps

module context_store import remove_v_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    ctx_if.store  ctx
);

    // column and row counters
    logic [SIZE_W-1:0] cnt_h_q [FLUX_COUNT];
    logic [SIZE_W-1:0] cnt_v_q [FLUX_COUNT];

    // frame width and height loaded at frame start
    logic [SIZE_W-1:0] max_h_q [FLUX_COUNT];
    logic [SIZE_W-1:0] max_v_q [FLUX_COUNT];

    // combinational read of the selected flux
    assign ctx.cnt_h = cnt_h_q[ctx.sel_tag];
    assign ctx.cnt_v = cnt_v_q[ctx.sel_tag];
    assign ctx.max_h = max_h_q[ctx.sel_tag];
    assign ctx.max_v = max_v_q[ctx.sel_tag];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FLUX_COUNT; i++)
            begin
                cnt_h_q[i] <= '0;
                cnt_v_q[i] <= '0;
                max_h_q[i] <= '0;
                max_v_q[i] <= '0;
            end
        end
        else if (ctx.op_valid)
        begin
            // both counters move together
            if (ctx.cnt_we)
            begin
                cnt_h_q[ctx.sel_tag] <= ctx.cnt_h_next;
                cnt_v_q[ctx.sel_tag] <= ctx.cnt_v_next;
            end

            // sizes only change at frame start
            if (ctx.max_we)
            begin
                max_h_q[ctx.sel_tag] <= ctx.max_h_next;
                max_v_q[ctx.sel_tag] <= ctx.max_v_next;
            end
        end
    end

    // control must never request an update without an operation
    a_write_needs_op: assert property (
        @(posedge clk) disable iff (rst)
        (ctx.cnt_we || ctx.max_we) |-> ctx.op_valid
    ) else $error("context write on flux %0d without op_valid", ctx.sel_tag);

    // a size load must leave the selected flux with counters at zero
    a_load_from_clear: assert property (
        @(posedge clk) disable iff (rst)
        (ctx.op_valid && ctx.max_we) |-> (ctx.cnt_h == '0 && ctx.cnt_v == '0)
    ) else $error("size load on flux %0d with cnt_h=%h cnt_v=%h",
                  ctx.sel_tag, ctx.cnt_h, ctx.cnt_v);

endmodule

/* remove_v_ctrl.sv */
// border removal control
`timescale 1ns/1ps

module remove_v_ctrl import remove_v_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               grant_valid,
    input  logic [TAG_W-1:0]                   grant_tag,
    input  logic [FLUX_COUNT-1:0][PEL_W-1:0]   pel_data,
    input  logic [FLUX_COUNT-1:0][SIZE_W-1:0]  ext_size_data,
    input  logic [FLUX_COUNT-1:0][SIZE_W-1:0]  real_size_data,
    output logic [FLUX_COUNT-1:0][PHASE_W-1:0] phase,
    output logic [FLUX_COUNT-1:0]              pel_read,
    output logic [FLUX_COUNT-1:0]              ext_size_read,
    output logic [FLUX_COUNT-1:0]              real_size_read,
    output logic [OUT_W-1:0]                   out_data,
    output logic                               out_write,
    ctx_if.ctrl                                ctx
);

    logic               active;
    logic [PHASE_W-1:0] cur_phase;
    logic [PHASE_W-1:0] phase_next;
    logic [SIZE_W-1:0]  h_last;
    logic [SIZE_W-1:0]  v_last;
    logic               row_end;
    logic               rd_pel;
    logic               rd_sizes;
    logic               wr_out;

    // no FIFO word is consumed while the phases are held in reset
    assign active = grant_valid && !rst;

    assign ctx.sel_tag = grant_tag;
    assign ctx.op_valid = active;
    assign ctx.max_h_next = real_size_data[grant_tag];
    assign ctx.max_v_next = ext_size_data[grant_tag];

    always_comb
    begin
        cur_phase = phase[grant_tag];
        h_last = ctx.max_h - SIZE_W'(1);
        v_last = ctx.max_v - SIZE_W'(1);
        row_end = (ctx.cnt_h >= h_last);

        rd_pel = 1'b0;
        rd_sizes = 1'b0;
        wr_out = 1'b0;
        phase_next = cur_phase;
        ctx.cnt_h_next = ctx.cnt_h;
        ctx.cnt_v_next = ctx.cnt_v;
        ctx.cnt_we = 1'b0;
        ctx.max_we = 1'b0;

        if (active)
        begin
            case (cur_phase)
                PHASE_W'(PH_IDLE):
                begin
                    // frame start takes height and width together
                    rd_sizes = 1'b1;
                    ctx.max_we = 1'b1;
                    phase_next = PHASE_W'(PH_DROP);
                end
                PHASE_W'(PH_DROP):
                begin
                    rd_pel = 1'b1;
                    ctx.cnt_we = 1'b1;
                    if (!row_end)
                    begin
                        ctx.cnt_h_next = ctx.cnt_h + SIZE_W'(1);
                    end
                    else
                    begin
                        ctx.cnt_h_next = '0;
                        ctx.cnt_v_next = ctx.cnt_v + SIZE_W'(1);
                        // last dropped row done
                        if (ctx.cnt_v >= SIZE_W'(DROP_ROWS - 1))
                        begin
                            phase_next = PHASE_W'(PH_WORK);
                        end
                    end
                end
                PHASE_W'(PH_WORK):
                begin
                    rd_pel = 1'b1;
                    wr_out = 1'b1;
                    ctx.cnt_we = 1'b1;
                    if (!row_end)
                    begin
                        ctx.cnt_h_next = ctx.cnt_h + SIZE_W'(1);
                    end
                    else if (ctx.cnt_v < v_last)
                    begin
                        ctx.cnt_h_next = '0;
                        ctx.cnt_v_next = ctx.cnt_v + SIZE_W'(1);
                    end
                    else
                    begin
                        // last pixel of the frame returns to idle
                        ctx.cnt_h_next = '0;
                        ctx.cnt_v_next = '0;
                        phase_next = PHASE_W'(PH_IDLE);
                    end
                end
                default:
                begin
                    phase_next = PHASE_W'(PH_IDLE);
                end
            endcase
        end
    end

    // strobes go only to the granted flux
    always_comb
    begin
        pel_read = '0;
        ext_size_read = '0;
        real_size_read = '0;
        pel_read[grant_tag] = rd_pel;
        ext_size_read[grant_tag] = rd_sizes;
        real_size_read[grant_tag] = rd_sizes;
    end

    // pixel passes straight through with its flux number on top
    assign out_data = {grant_tag, pel_data[grant_tag]};
    assign out_write = wr_out;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FLUX_COUNT; i++)
            begin
                phase[i] <= PHASE_W'(PH_IDLE);
            end
        end
        else if (active)
        begin
            phase[grant_tag] <= phase_next;
        end
    end

    // a working flux always sits in the kept rows of its frame
    a_work_in_kept_rows: assert property (
        @(posedge clk) disable iff (rst)
        (active && cur_phase == PHASE_W'(PH_WORK))
            |-> (ctx.cnt_v >= SIZE_W'(DROP_ROWS) && ctx.cnt_v < ctx.max_v)
    ) else $error("flux %0d working on row %h of height %h",
                  grant_tag, ctx.cnt_v, ctx.max_v);

endmodule

/* remove_v.sv */
// top border removal engine
`timescale 1ns/1ps

module remove_v import remove_v_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    // pixel input FIFOs
    input  logic [FLUX_COUNT-1:0]             pel_empty,
    input  logic [FLUX_COUNT-1:0][PEL_W-1:0]  pel_data,
    output logic [FLUX_COUNT-1:0]             pel_read,

    // frame height FIFOs
    input  logic [FLUX_COUNT-1:0]             ext_size_empty,
    input  logic [FLUX_COUNT-1:0][SIZE_W-1:0] ext_size_data,
    output logic [FLUX_COUNT-1:0]             ext_size_read,

    // frame width FIFOs
    input  logic [FLUX_COUNT-1:0]             real_size_empty,
    input  logic [FLUX_COUNT-1:0][SIZE_W-1:0] real_size_data,
    output logic [FLUX_COUNT-1:0]             real_size_read,

    // shared output FIFO with one full flag per flux
    input  logic [FLUX_COUNT-1:0]             out_full,
    output logic [OUT_W-1:0]                  out_data,
    output logic                              out_write
);

    logic [FLUX_COUNT-1:0][PHASE_W-1:0] phase;
    logic                               grant_valid;
    logic [TAG_W-1:0]                   grant_tag;

    ctx_if ctx_bus ();

    flux_arbiter flux_arbiter_i
    (
        .phase           (phase),
        .pel_empty       (pel_empty),
        .ext_size_empty  (ext_size_empty),
        .real_size_empty (real_size_empty),
        .out_full        (out_full),
        .grant_valid     (grant_valid),
        .grant_tag       (grant_tag)
    );

    context_store context_store_i
    (
        .clk (clk),
        .rst (rst),
        .ctx (ctx_bus.store)
    );

    remove_v_ctrl remove_v_ctrl_i
    (
        .clk            (clk),
        .rst            (rst),
        .grant_valid    (grant_valid),
        .grant_tag      (grant_tag),
        .pel_data       (pel_data),
        .ext_size_data  (ext_size_data),
        .real_size_data (real_size_data),
        .phase          (phase),
        .pel_read       (pel_read),
        .ext_size_read  (ext_size_read),
        .real_size_read (real_size_read),
        .out_data       (out_data),
        .out_write      (out_write),
        .ctx            (ctx_bus.ctrl)
    );

endmodule

/* tb_remove_v.sv */
// border removal testbench
`timescale 1ns/1ps

module tb_remove_v import remove_v_pkg::*; ();

    localparam int FRAMES = 6;
    // 2 x 6 x 180 pixels plus size reads, with room for random stalls
    localparam int TIMEOUT_CYCLES = 20000;

    logic                              clk;
    logic                              rst;
    logic [FLUX_COUNT-1:0]             pel_empty;
    logic [FLUX_COUNT-1:0][PEL_W-1:0]  pel_data;
    logic [FLUX_COUNT-1:0]             pel_read;
    logic [FLUX_COUNT-1:0]             ext_size_empty;
    logic [FLUX_COUNT-1:0][SIZE_W-1:0] ext_size_data;
    logic [FLUX_COUNT-1:0]             ext_size_read;
    logic [FLUX_COUNT-1:0]             real_size_empty;
    logic [FLUX_COUNT-1:0][SIZE_W-1:0] real_size_data;
    logic [FLUX_COUNT-1:0]             real_size_read;
    logic [FLUX_COUNT-1:0]             out_full;
    logic [OUT_W-1:0]                  out_data;
    logic                              out_write;

    integer seed;
    int     cycles;
    int     data_errors;
    int     proto_errors;

    // FIFO contents and expected output per flux
    logic [PEL_W-1:0]  pel_q  [FLUX_COUNT][$];
    logic [SIZE_W-1:0] ext_q  [FLUX_COUNT][$];
    logic [SIZE_W-1:0] real_q [FLUX_COUNT][$];
    logic [PEL_W-1:0]  exp_q  [FLUX_COUNT][$];

    // model phase and pixels left in the dropped and kept parts of a frame
    int m_phase   [FLUX_COUNT];
    int drop_left [FLUX_COUNT];
    int fwd_left  [FLUX_COUNT];

    remove_v remove_v_i
    (
        .clk             (clk),
        .rst             (rst),
        .pel_empty       (pel_empty),
        .pel_data        (pel_data),
        .pel_read        (pel_read),
        .ext_size_empty  (ext_size_empty),
        .ext_size_data   (ext_size_data),
        .ext_size_read   (ext_size_read),
        .real_size_empty (real_size_empty),
        .real_size_data  (real_size_data),
        .real_size_read  (real_size_read),
        .out_full        (out_full),
        .out_data        (out_data),
        .out_write       (out_write)
    );

    always #4 clk = ~clk;

    task automatic build_frames();
        int h;
        int w;
        logic [PEL_W-1:0] p;
        for (int f = 0; f < FLUX_COUNT; f++)
        begin
            for (int n = 0; n < FRAMES; n++)
            begin
                h = 8 + int'($unsigned($random(seed)) % 8);
                w = 2 + int'($unsigned($random(seed)) % 11);
                ext_q[f].push_back(SIZE_W'(h));
                real_q[f].push_back(SIZE_W'(w));
                for (int r = 0; r < h; r++)
                begin
                    for (int c = 0; c < w; c++)
                    begin
                        p = PEL_W'($random(seed));
                        pel_q[f].push_back(p);
                        // top rows never reach the output
                        if (r >= DROP_ROWS)
                        begin
                            exp_q[f].push_back(p);
                        end
                    end
                end
            end
        end
    endtask

    task automatic drive_inputs();
        for (int f = 0; f < FLUX_COUNT; f++)
        begin
            // a FIFO holding data still looks empty now and then
            pel_empty[f] = (pel_q[f].size() == 0) || (($random(seed) & 3) == 0);
            ext_size_empty[f] = (ext_q[f].size() == 0) || (($random(seed) & 3) == 0);
            real_size_empty[f] = (real_q[f].size() == 0) || (($random(seed) & 3) == 0);
            pel_data[f] = (pel_q[f].size() != 0) ? pel_q[f][0] : '0;
            ext_size_data[f] = (ext_q[f].size() != 0) ? ext_q[f][0] : '0;
            real_size_data[f] = (real_q[f].size() != 0) ? real_q[f][0] : '0;
            out_full[f] = (($random(seed) & 3) == 0);
        end
    endtask

    function automatic logic is_eligible(logic [TAG_W-1:0] f);
        case (m_phase[f])
            PH_IDLE: return !ext_size_empty[f] && !real_size_empty[f];
            PH_DROP: return !pel_empty[f];
            default: return !pel_empty[f] && !out_full[f];
        endcase
    endfunction

    function automatic logic run_complete();
        logic done;
        done = 1'b1;
        for (int f = 0; f < FLUX_COUNT; f++)
        begin
            if (pel_q[f].size() != 0 || ext_q[f].size() != 0 || real_q[f].size() != 0)
            begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic load_frame(logic [TAG_W-1:0] f);
        int h;
        int w;
        assert (m_phase[f] == PH_IDLE)
        else
        begin
            $display("flux %0d read new frame sizes before its frame ended", f);
            proto_errors++;
        end
        h = int'(ext_q[f].pop_front());
        w = int'(real_q[f].pop_front());
        drop_left[f] = DROP_ROWS * w;
        fwd_left[f] = (h - DROP_ROWS) * w;
        m_phase[f] = PH_DROP;
    endtask

    task automatic take_pixel(logic [TAG_W-1:0] f);
        logic [PEL_W-1:0] pel;
        logic [PEL_W-1:0] expected;
        pel = pel_q[f].pop_front();
        assert (m_phase[f] != PH_IDLE)
        else
        begin
            $display("flux %0d read a pixel before its frame sizes", f);
            proto_errors++;
        end
        if (m_phase[f] == PH_DROP)
        begin
            assert (!out_write)
            else
            begin
                $display("flux %0d wrote a pixel from a dropped row", f);
                data_errors++;
            end
            drop_left[f]--;
            if (drop_left[f] == 0)
            begin
                m_phase[f] = PH_WORK;
            end
        end
        else if (m_phase[f] == PH_WORK)
        begin
            assert (out_write && exp_q[f].size() != 0)
            else
            begin
                $display("flux %0d kept pixel not written or not expected", f);
                data_errors++;
            end
            if (out_write && exp_q[f].size() != 0)
            begin
                expected = exp_q[f].pop_front();
                assert (out_data[PEL_W-1:0] == expected)
                else
                begin
                    $display("** Error: out_data pixel of flux %0d got %h expected %h",
                             f, out_data[PEL_W-1:0], expected);
                    data_errors++;
                end
                assert (out_data[OUT_W-1 -: TAG_W] == f && out_data[PEL_W-1:0] == pel)
                else
                begin
                    $display("** Error: out_data got %h expected %h", out_data, {f, pel});
                    data_errors++;
                end
            end
            fwd_left[f]--;
            if (fwd_left[f] == 0)
            begin
                m_phase[f] = PH_IDLE;
            end
        end
    endtask

    always @(posedge clk)
    begin
        int ops;
        logic [TAG_W-1:0] tag;
        cycles++;
        if (rst)
        begin
            assert (pel_read == '0 && ext_size_read == '0 && real_size_read == '0 && !out_write)
            else
            begin
                $display("a strobe was high during reset");
                proto_errors++;
            end
        end
        else
        begin
            ops = 0;
            // priority check uses the model phases before this edge
            for (int f = 0; f < FLUX_COUNT; f++)
            begin
                if (pel_read[f])
                begin
                    ops++;
                end
                if (ext_size_read[f] || real_size_read[f])
                begin
                    ops++;
                end
                for (int g = 0; g < f; g++)
                begin
                    assert (!(pel_read[f] || ext_size_read[f] || real_size_read[f])
                            || !is_eligible(TAG_W'(g)))
                    else
                    begin
                        $display("flux %0d served while flux %0d was eligible", f, g);
                        proto_errors++;
                    end
                end
            end
            assert (ops <= 1)
            else
            begin
                $display("more than one FIFO operation in one cycle");
                proto_errors++;
            end
            if (out_write)
            begin
                tag = out_data[OUT_W-1 -: TAG_W];
                assert (!out_full[tag] && pel_read[tag])
                else
                begin
                    $display("flux %0d written while full or without a pixel read", tag);
                    proto_errors++;
                end
            end
            for (int f = 0; f < FLUX_COUNT; f++)
            begin
                assert (!(pel_read[f] && pel_empty[f]) && !(ext_size_read[f] && ext_size_empty[f])
                        && !(real_size_read[f] && real_size_empty[f]))
                else
                begin
                    $display("flux %0d read from an empty FIFO", f);
                    proto_errors++;
                end
                assert (ext_size_read[f] == real_size_read[f])
                else
                begin
                    $display("flux %0d did not read both frame sizes together", f);
                    proto_errors++;
                end
                if (ext_size_read[f] && !ext_size_empty[f] && !real_size_empty[f])
                begin
                    load_frame(TAG_W'(f));
                end
                if (pel_read[f] && !pel_empty[f])
                begin
                    take_pixel(TAG_W'(f));
                end
            end
        end
    end

    initial
    begin
        seed = 32'h04ad_14b8;
        clk = 1'b0;
        rst = 1'b1;
        cycles = 0;
        data_errors = 0;
        proto_errors = 0;
        for (int f = 0; f < FLUX_COUNT; f++)
        begin
            m_phase[f] = PH_IDLE;
            drop_left[f] = 0;
            fwd_left[f] = 0;
        end
        build_frames();
        // FIFOs already show data while reset is held
        drive_inputs();
        repeat (3) @(posedge clk);
        while (!run_complete() && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            rst = 1'b0;
            drive_inputs();
        end
        assert (run_complete())
        else
        begin
            $display("timeout, FIFOs not drained after %0d cycles", TIMEOUT_CYCLES);
            proto_errors++;
        end
        for (int f = 0; f < FLUX_COUNT; f++)
        begin
            assert (exp_q[f].size() == 0 && m_phase[f] == PH_IDLE)
            else
            begin
                $display("flux %0d ended with %0d expected pixels missing", f, exp_q[f].size());
                data_errors++;
            end
        end
        $display("errors: %0d data, %0d protocol, %0d cycles", data_errors, proto_errors, cycles);
        if (data_errors == 0 && proto_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* remove_v.f */
remove_v_pkg.sv
ctx_if.sv
flux_arbiter.sv
context_store.sv
remove_v_ctrl.sv
remove_v.sv
tb_remove_v.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_remove_v -f remove_v.f
	./obj_dir/Vtb_remove_v > sim.log
	cat sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log
